// File: source/st_io_consts.svh
// widths, FIFO depths and control bit positions; the FIFO depths must be powers of two
`ifndef ST_IO_CONSTS_SVH
`define ST_IO_CONSTS_SVH

// data path widths
`define ST_BYTE_W      8
`define ST_CTRL_W      32   // system control word from the io controller
`define ST_JOY_W       16   // extra joystick word as sent by the io controller

// output FIFO depths
`define ST_MIDI_DEPTH  8
`define ST_PAR_DEPTH   4

// idle cycles after each byte taken by the host
`define ST_BYTE_GAP    3

// joystick word layout, directions in bits 3:0
`define ST_JOY_FIRE    4

// positions in the system control word
`define ST_CTRL_RESET     0    // core reset
`define ST_CTRL_WP_LO     6    // floppy write protect, two bits
`define ST_CTRL_REDIR_LO  26   // usb redirection target, two bits

`endif

// File: source/st_ctrl_pkg.sv
// control word layout; field positions come from the consts header and must not overlap
`include "st_io_consts.svh"

package st_ctrl_pkg;

	// usb target port on the io controller
	typedef enum logic [1:0] {
		REDIR_NONE    = 2'd0,
		REDIR_RS232   = 2'd1,
		REDIR_PRINTER = 2'd2,   // busy comes from the parallel fifo
		REDIR_MIDI    = 2'd3
	} redirect_e;

	// msb first, fillers cover video and other unused bits
	typedef struct packed {
		logic [`ST_CTRL_W-`ST_CTRL_REDIR_LO-3:0]          fill_hi;     // blend, misc
		redirect_e                                        redirection; // 27:26
		logic [`ST_CTRL_REDIR_LO-`ST_CTRL_WP_LO-3:0]      fill_mid;    // scanlines etc
		logic [1:0]                                       fdc_wp;      // 7:6
		logic [`ST_CTRL_WP_LO-`ST_CTRL_RESET-2:0]         fill_lo;
		logic                                             core_reset;  // bit 0
	} sys_ctrl_fields_t;

	// host writes raw, router reads fields
	typedef union packed {
		logic [`ST_CTRL_W-1:0] raw;
		sys_ctrl_fields_t      f;
	} sys_ctrl_u;

endpackage

// File: source/st_port_pkg.sv
// byte stream and joystick types; joystick word is active high as the io controller sends it
`include "st_io_consts.svh"

package st_port_pkg;

	// which fifo a host byte came from
	typedef enum logic {
		SRC_MIDI = 1'b0,
		SRC_PAR  = 1'b1
	} byte_src_e;

	// tagged byte toward the io controller
	typedef struct packed {
		logic [`ST_BYTE_W-1:0] data;
		byte_src_e             src;
	} io_byte_t;

	// bits 3:0 directions, bit 4 fire, rest buttons
	typedef logic [`ST_JOY_W-1:0] joy_t;

endpackage

// File: source/io_fifo.sv
// single clock byte fifo; DEPTH must be a power of two, writes when full are dropped
`timescale 1ns/1ps
`include "st_io_consts.svh"

module io_fifo #(
	parameter int DEPTH = 8
) (
	input  logic                  clk_32,
	input  logic                  arst_n,
	input  logic                  wr,     // one cycle write strobe
	input  logic [`ST_BYTE_W-1:0] din,
	input  logic                  rd,     // pop head, only while avail
	output logic [`ST_BYTE_W-1:0] dout,   // head entry, combinational
	output logic                  avail,
	output logic                  full
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	logic [`ST_BYTE_W-1:0] mem [DEPTH];
	logic [AW-1:0]         wr_ptr, rd_ptr;  // wrap naturally at DEPTH
	logic [CW-1:0]         count;
	logic                  wr_en, rd_en;

	assign wr_en = wr && !full;
	assign rd_en = rd && avail;   // ignore pops on empty

	assign avail = (count != '0);
	assign full  = (count == CW'(DEPTH));
	assign dout  = mem[rd_ptr];

	// storage, no reset on payload
	always_ff @(posedge clk_32) begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// push and pop together keep count
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

endmodule

// File: source/byte_gap_timer.sv
// holds off the next host byte for ST_BYTE_GAP cycles after start; expired out of reset
`timescale 1ns/1ps
`include "st_io_consts.svh"

module byte_gap_timer (
	input  logic clk_32,
	input  logic arst_n,
	input  logic start,    // reload, wins over counting
	output logic expired
);

	localparam int GW = $clog2(`ST_BYTE_GAP + 1);

	logic [GW-1:0] cnt;

	assign expired = (cnt == '0);

	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n)
			cnt <= '0;   // expired
		else if (start)
			cnt <= GW'(`ST_BYTE_GAP);
		else if (!expired)
			cnt <= cnt - 1'b1;   // stop at zero
	end

endmodule

// File: source/drain_sequencer.sv
// drains midi and parallel fifos into one tagged stream; byte held stable until host_ready
`timescale 1ns/1ps
`include "st_io_consts.svh"

module drain_sequencer import st_port_pkg::*; (
	input  logic                  clk_32,
	input  logic                  arst_n,
	input  logic                  midi_avail,
	input  logic                  par_avail,
	input  logic [`ST_BYTE_W-1:0] midi_dout,
	input  logic [`ST_BYTE_W-1:0] par_dout,
	output logic                  midi_rd,
	output logic                  par_rd,
	output io_byte_t              host_byte,
	output logic                  host_valid,
	input  logic                  host_ready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_POP,    // strobe rd, capture head
		S_SEND    // offer byte until accepted
	} state_t;

	state_t    state;
	byte_src_e sel;        // fifo picked for this transfer
	byte_src_e last;       // last served, for alternation
	byte_src_e pick;
	logic      gap_done;
	logic      accept;

	// both ready: take the other one than last time
	always_comb begin
		if (midi_avail && par_avail)
			pick = (last == SRC_MIDI) ? SRC_PAR : SRC_MIDI;
		else if (midi_avail)
			pick = SRC_MIDI;
		else
			pick = SRC_PAR;
	end

	assign midi_rd    = (state == S_POP) && (sel == SRC_MIDI);
	assign par_rd     = (state == S_POP) && (sel == SRC_PAR);
	assign host_valid = (state == S_SEND);
	assign accept     = host_valid && host_ready;

	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			sel   <= SRC_MIDI;
			last  <= SRC_PAR;   // so midi goes first
		end else begin
			case (state)
				S_IDLE: if (gap_done && (midi_avail || par_avail)) begin
					sel   <= pick;
					state <= S_POP;
				end
				S_POP: begin
					last  <= sel;
					state <= S_SEND;
				end
				S_SEND: if (host_ready)
					state <= S_IDLE;   // back-pressure just waits here
				default: state <= S_IDLE;
			endcase
		end
	end

	// payload, loaded on the pop cycle only
	always_ff @(posedge clk_32) begin
		if (state == S_POP) begin
			host_byte.data <= (sel == SRC_MIDI) ? midi_dout : par_dout;
			host_byte.src  <= sel;
		end
	end

	byte_gap_timer gap_timer (
		.clk_32  (clk_32),
		.arst_n  (arst_n),
		.start   (accept),     // spacing starts on each accepted byte
		.expired (gap_done)
	);

endmodule

// File: source/port_router.sv
// control register and port mapping; outputs are combinational from the register and joysticks
`timescale 1ns/1ps
`include "st_io_consts.svh"

module port_router import st_ctrl_pkg::*, st_port_pkg::*; (
	input  logic                  clk_32,
	input  logic                  arst_n,
	input  logic                  ctrl_load,    // one cycle strobe from the io controller
	input  sys_ctrl_u             ctrl_word,
	input  logic                  par_full,
	input  joy_t                  joy2,
	input  joy_t                  joy3,
	output logic                  core_reset,
	output logic [1:0]            fdc_wp,
	output logic                  printer_busy,
	output logic [`ST_BYTE_W-1:0] parallel_in,
	output logic                  parallel_in_strobe
);

	sys_ctrl_u ctrl_q;

	// clears to zero, so redirection none and core out of reset
	always_ff @(posedge clk_32 or negedge arst_n) begin
		if (!arst_n)
			ctrl_q.raw <= '0;
		else if (ctrl_load)
			ctrl_q <= ctrl_word;
	end

	assign core_reset = ctrl_q.f.core_reset;
	assign fdc_wp     = ctrl_q.f.fdc_wp;

	// printer redirection: busy while the parallel fifo cannot take more
	// otherwise busy is fire of joystick 2 on the gauntlet adapter
	always_comb begin
		if (ctrl_q.f.redirection == REDIR_PRINTER)
			printer_busy = par_full;
		else
			printer_busy = joy2[`ST_JOY_FIRE];
	end

	// gauntlet adapter, lines are active low on the port
	assign parallel_in = {
		~joy2[0], ~joy2[1], ~joy2[2], ~joy2[3],   // upper nibble
		~joy3[0], ~joy3[1], ~joy3[2], ~joy3[3]    // lower nibble
	};
	assign parallel_in_strobe = ~joy3[`ST_JOY_FIRE];   // joy3 fire on strobe

endmodule

// File: source/st_io_top.sv
// host side io glue on clk_32 only; core_reset is an output and does not clear the fifos
`timescale 1ns/1ps
`include "st_io_consts.svh"

module st_io_top import st_ctrl_pkg::*, st_port_pkg::*; (
	input  logic                  clk_32,
	input  logic                  arst_n,
	input  logic                  midi_wr,      // acia data write
	input  logic [`ST_BYTE_W-1:0] midi_byte,
	input  logic                  par_wr,       // psg port write
	input  logic [`ST_BYTE_W-1:0] par_byte,
	input  logic                  ctrl_load,
	input  sys_ctrl_u             ctrl_word,
	input  joy_t                  joy2,
	input  joy_t                  joy3,
	input  logic                  host_ready,
	output io_byte_t              host_byte,
	output logic                  host_valid,
	output logic                  core_reset,
	output logic [1:0]            fdc_wp,
	output logic                  printer_busy,
	output logic [`ST_BYTE_W-1:0] parallel_in,
	output logic                  parallel_in_strobe
);

	logic                  midi_rd, midi_avail;
	logic                  par_rd, par_avail, par_full;
	logic [`ST_BYTE_W-1:0] midi_dout, par_dout;

	io_fifo #(.DEPTH(`ST_MIDI_DEPTH)) midi_fifo (
		.clk_32 (clk_32),
		.arst_n (arst_n),
		.wr     (midi_wr),
		.din    (midi_byte),
		.rd     (midi_rd),
		.dout   (midi_dout),
		.avail  (midi_avail),
		.full   ()              // midi drops on overflow
	);

	io_fifo #(.DEPTH(`ST_PAR_DEPTH)) par_fifo (
		.clk_32 (clk_32),
		.arst_n (arst_n),
		.wr     (par_wr),
		.din    (par_byte),
		.rd     (par_rd),
		.dout   (par_dout),
		.avail  (par_avail),
		.full   (par_full)      // feeds printer busy
	);

	drain_sequencer drain (
		.clk_32     (clk_32),
		.arst_n     (arst_n),
		.midi_avail (midi_avail),
		.par_avail  (par_avail),
		.midi_dout  (midi_dout),
		.par_dout   (par_dout),
		.midi_rd    (midi_rd),
		.par_rd     (par_rd),
		.host_byte  (host_byte),
		.host_valid (host_valid),
		.host_ready (host_ready)
	);

	port_router router (
		.clk_32             (clk_32),
		.arst_n             (arst_n),
		.ctrl_load          (ctrl_load),
		.ctrl_word          (ctrl_word),
		.par_full           (par_full),
		.joy2               (joy2),
		.joy3               (joy3),
		.core_reset         (core_reset),
		.fdc_wp             (fdc_wp),
		.printer_busy       (printer_busy),
		.parallel_in        (parallel_in),
		.parallel_in_strobe (parallel_in_strobe)
	);

endmodule

// File: test/st_io_checker.sv
// protocol assertions bound into st_io_top; active only while arst_n is high
`timescale 1ns/1ps
`include "st_io_consts.svh"

module st_io_checker import st_port_pkg::*; (
	input logic     clk_32,
	input logic     arst_n,
	input io_byte_t host_byte,
	input logic     host_valid,
	input logic     host_ready,
	input logic     midi_rd,
	input logic     midi_avail,
	input logic     par_rd,
	input logic     par_avail
);

	// offered byte must not move until the host takes it
	property byte_held;
		@(posedge clk_32) disable iff (!arst_n)
		host_valid && !host_ready |=> host_valid && $stable(host_byte);
	endproperty

	assert property (byte_held)
		else $error("host_byte changed or valid dropped before ready");
	assert property (@(posedge clk_32) disable iff (!arst_n) midi_rd |-> midi_avail)
		else $error("midi fifo popped while empty");
	assert property (@(posedge clk_32) disable iff (!arst_n) par_rd |-> par_avail)
		else $error("parallel fifo popped while empty");
	assert property (@(posedge clk_32) disable iff (!arst_n) !(midi_rd && par_rd))
		else $error("both fifos popped in one cycle");   // one source per transfer

endmodule

bind st_io_top st_io_checker checker_inst (
	.clk_32     (clk_32),
	.arst_n     (arst_n),
	.host_byte  (host_byte),
	.host_valid (host_valid),
	.host_ready (host_ready),
	.midi_rd    (midi_rd),
	.midi_avail (midi_avail),
	.par_rd     (par_rd),
	.par_avail  (par_avail)
);

// File: test/st_io_tb.sv
// self-checking bench for st_io_top; 2000 cycle limit and random host_ready only while streaming
`timescale 1ns/1ps
`include "st_io_consts.svh"

module st_io_tb import st_ctrl_pkg::*, st_port_pkg::*; ();

	localparam int CYCLE_LIMIT = 2000;   // ~60 bytes at pop, gap and stall cost, doubled

	typedef struct packed {
		logic                  busy;
		logic [`ST_BYTE_W-1:0] pin;
		logic                  strobe;
	} port_t;

	logic clk_32 = 1'b0;
	logic arst_n, midi_wr, par_wr, ctrl_load, host_ready;
	logic [`ST_BYTE_W-1:0] midi_byte, par_byte, parallel_in;
	sys_ctrl_u ctrl_word, cur_ctrl, w;
	joy_t      joy2, joy3;
	io_byte_t  host_byte, want;
	logic      host_valid, core_reset, printer_busy, parallel_in_strobe;
	logic [1:0] fdc_wp;
	logic [`ST_BYTE_W-1:0] midi_q[$];   // expected bytes per source, in write order
	logic [`ST_BYTE_W-1:0] par_q[$];
	integer    seed;
	int        cycles = 0;
	int        err_byte = 0, err_ctrl = 0, err_port = 0, err_other = 0;
	logic [1:0] ready_mode;   // 0 low, 1 high, 2 random
	logic      alt_check = 1'b0, alt_seen = 1'b0;
	byte_src_e prev_src;

	st_io_top DUT (.*);

	always #20 clk_32 = ~clk_32;   // 40 ns period

	// msb of a stimulus byte names the fifo it was written to
	function automatic bit next_expected(input logic [`ST_BYTE_W-1:0] data,
			output io_byte_t e);
		e.src  = data[`ST_BYTE_W-1] ? SRC_PAR : SRC_MIDI;
		e.data = '0;
		if (e.src == SRC_MIDI && midi_q.size() != 0) begin
			e.data = midi_q.pop_front();
			return 1'b1;
		end
		if (e.src == SRC_PAR && par_q.size() != 0) begin
			e.data = par_q.pop_front();
			return 1'b1;
		end
		return 1'b0;
	endfunction

	// router rules taken straight from the raw control bits
	function automatic port_t port_ref(input sys_ctrl_u c, input joy_t j2, input joy_t j3,
			input logic pfull);
		port_t r;
		r.busy = (c.raw[`ST_CTRL_REDIR_LO +: 2] == 2'd2) ? pfull : j2[`ST_JOY_FIRE];
		for (int i = 0; i < 4; i++) begin
			r.pin[7 - i] = ~j2[i];   // joy2 bit 0 lands on msb
			r.pin[3 - i] = ~j3[i];
		end
		r.strobe = ~j3[`ST_JOY_FIRE];
		return r;
	endfunction

	task automatic check_byte(input io_byte_t got, input io_byte_t exp_b);
		if (got !== exp_b) begin
			err_byte++;
			$display("Error: host_byte got %h expected %h", got, exp_b);
		end
	endtask

	task automatic check_ctrl(input logic got_rst, input logic [1:0] got_wp, input sys_ctrl_u c);
		if (got_rst !== c.raw[`ST_CTRL_RESET]) begin
			err_ctrl++;
			$display("Error: core_reset got %h expected %h", got_rst, c.raw[`ST_CTRL_RESET]);
		end
		if (got_wp !== c.raw[`ST_CTRL_WP_LO +: 2]) begin
			err_ctrl++;
			$display("Error: fdc_wp got %h expected %h", got_wp, c.raw[`ST_CTRL_WP_LO +: 2]);
		end
	endtask

	task automatic check_port(input port_t got, input port_t exp_p);
		if (got.busy !== exp_p.busy) begin
			err_port++;
			$display("Error: printer_busy got %h expected %h", got.busy, exp_p.busy);
		end
		if (got.pin !== exp_p.pin) begin
			err_port++;
			$display("Error: parallel_in got %h expected %h", got.pin, exp_p.pin);
		end
		if (got.strobe !== exp_p.strobe) begin
			err_port++;
			$display("Error: parallel_in_strobe got %h expected %h", got.strobe, exp_p.strobe);
		end
	endtask

	task automatic step();
		@(posedge clk_32);
		#1;   // inputs change just after the edge
		case (ready_mode)   // host side ready for the coming cycle
			2'd0:    host_ready = 1'b0;
			2'd1:    host_ready = 1'b1;
			default: host_ready = 1'($random(seed));
		endcase
	endtask

	task automatic load_ctrl(input sys_ctrl_u c);
		ctrl_word = c;
		ctrl_load = 1'b1;
		cur_ctrl  = c;
		step();
		ctrl_load = 1'b0;
	endtask

	task automatic push_bytes(input bit m, input bit p);
		midi_byte = {1'b0, 7'($random(seed))};   // msb clear for midi
		par_byte  = {1'b1, 7'($random(seed))};   // msb set for parallel
		midi_wr   = m;
		par_wr    = p;
		if (m)
			midi_q.push_back(midi_byte);
		if (p)
			par_q.push_back(par_byte);
		step();
		midi_wr = 1'b0;
		par_wr  = 1'b0;
	endtask

	task automatic wait_drain();
		while (midi_q.size() != 0 || par_q.size() != 0)
			step();
		repeat (`ST_BYTE_GAP + 2) step();   // back to idle with the gap run out
	endtask

	// sampled at the falling edge before the transfer edge
	always @(negedge clk_32) begin
		if (arst_n && host_valid && host_ready) begin
			if (!next_expected(host_byte.data, want)) begin
				err_other++;
				$display("host sent byte %h with nothing pending from that source", host_byte);
			end else
				check_byte(host_byte, want);
			if (alt_check && alt_seen && host_byte.src == prev_src) begin
				err_other++;
				$display("two bytes in a row from one source while both fifos held data");
			end
			prev_src = host_byte.src;
			alt_seen = 1'b1;
		end
	end

	always @(posedge clk_32) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		seed       = 40;
		arst_n     = 1'b0;
		midi_wr    = 1'b0;
		par_wr     = 1'b0;
		midi_byte  = '0;
		par_byte   = '0;
		ctrl_load  = 1'b0;
		ctrl_word  = '0;
		cur_ctrl   = '0;
		joy2       = '0;
		joy3       = '0;
		host_ready = 1'b0;
		ready_mode = 2'd1;
		repeat (4) step();
		arst_n = 1'b1;

		// reset state with empty fifos and no traffic
		check_ctrl(core_reset, fdc_wp, '0);
		repeat (10) begin
			step();
			if (host_valid !== 1'b0) begin
				err_other++;
				$display("host_valid raised with both fifos empty");
			end
		end

		// control word decode
		repeat (6) begin
			w.raw = 32'($random(seed));
			load_ctrl(w);
			check_ctrl(core_reset, fdc_wp, cur_ctrl);
			check_port({printer_busy, parallel_in, parallel_in_strobe},
				port_ref(cur_ctrl, joy2, joy3, 1'b0));
		end

		// stream content under random back-pressure with bursts below depth
		ready_mode = 2'd2;
		repeat (4) begin
			for (int i = 0; i < `ST_MIDI_DEPTH - 2; i++)
				push_bytes(1'b1, i < `ST_PAR_DEPTH - 1);
			wait_drain();
		end

		// alternation with both fifos loaded before the host takes anything
		ready_mode = 2'd0;
		repeat (3) push_bytes(1'b1, 1'b1);
		alt_seen   = 1'b0;
		alt_check  = 1'b1;
		ready_mode = 2'd1;
		wait_drain();
		alt_check = 1'b0;

		// printer busy needs depth+1 writes since one byte sits in the sequencer
		w.raw           = '0;
		w.f.redirection = REDIR_PRINTER;
		load_ctrl(w);
		ready_mode = 2'd0;
		repeat (`ST_PAR_DEPTH + 1) push_bytes(1'b0, 1'b1);
		repeat (2) step();
		check_port({printer_busy, parallel_in, parallel_in_strobe},
			port_ref(cur_ctrl, joy2, joy3, 1'b1));
		ready_mode = 2'd1;
		wait_drain();
		check_port({printer_busy, parallel_in, parallel_in_strobe},
			port_ref(cur_ctrl, joy2, joy3, 1'b0));

		// busy from joy2 fire and the gauntlet mapping
		w.f.redirection = REDIR_RS232;
		load_ctrl(w);
		repeat (12) begin
			joy2 = 16'($random(seed));
			joy3 = 16'($random(seed));
			step();
			check_port({printer_busy, parallel_in, parallel_in_strobe},
				port_ref(cur_ctrl, joy2, joy3, 1'b0));
		end

		repeat (5) step();
		if (midi_q.size() != 0 || par_q.size() != 0) begin
			err_other++;
			$display("bytes never reached the host, midi %0d parallel %0d",
				midi_q.size(), par_q.size());
		end
		$display("errors: byte %0d ctrl %0d port %0d other %0d",
			err_byte, err_ctrl, err_port, err_other);
		if (err_byte + err_ctrl + err_port + err_other == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: st_io.f
+incdir+source
source/st_ctrl_pkg.sv
source/st_port_pkg.sv
source/io_fifo.sv
source/byte_gap_timer.sv
source/drain_sequencer.sv
source/port_router.sv
source/st_io_top.sv
test/st_io_checker.sv
test/st_io_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= st_io_tb
RTL_TOP   ?= st_io_top
FILELIST  ?= st_io.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TB_TOP)

run: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || exit 1

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
